// ==== hdl/sonar_pkg.sv ====
`default_nettype none

package sonar_pkg;

	// widths with a meaning
	typedef logic signed [15:0] sample_t;	// signed audio sample
	typedef logic [39:0] energy_t;		// window sum of squares
	typedef logic [11:0] delay_t;		// sample index / delay in steps

	localparam int WINDOW_LEN = 8;		// samples per window
	localparam delay_t MAX_DELAY = 12'd255;	// last index examined per ping
	localparam int PAUSE_STEPS = 16;	// steps between pings
	localparam int MAX_PINGS = 6;		// pings before no-echo
	localparam int IMPULSE_LEN = 4;		// impulse length in samples
	localparam sample_t IMPULSE_AMP = 16'sd8192;

	// stored delay start values, never a window closing index below MAX_DELAY
	localparam delay_t NO_DELAY_NEW = 12'hfff;
	localparam delay_t NO_DELAY_OLD = 12'hffe;

	typedef struct packed {
		energy_t energy;
		delay_t last_index;	// index of the window's final sample
	} window_t;

	typedef struct packed {
		logic onset;
		delay_t last_index;
	} verdict_t;

	typedef enum logic {
		RANGE_OK,
		RANGE_NO_ECHO
	} range_status_t;

	typedef struct packed {
		range_status_t status;
		delay_t delay;
	} range_result_t;

endpackage

`default_nettype wire

// ==== hdl/impulse_generator.sv ====
`timescale 1ns/1ps
`default_nettype none

module impulse_generator (
	input logic clk_in,
	input logic rst_in,
	input logic step_in,
	input logic ping_fire,
	output logic emit_start,
	output sonar_pkg::sample_t amp_out
);

	logic armed;	// ping requested, waiting for next strobe
	logic playing;
	logic [$clog2(sonar_pkg::IMPULSE_LEN)-1:0] remaining;	// strobes left after current one

	// impulse sample 0 goes out on this strobe
	assign emit_start = armed && step_in;

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			armed <= 1'b0;
			playing <= 1'b0;
			remaining <= '0;
			amp_out <= '0;
		end else begin
			if (ping_fire && !playing && !armed) begin
				armed <= 1'b1;
			end

			if (emit_start) begin
				armed <= 1'b0;
				playing <= 1'b1;
				amp_out <= sonar_pkg::IMPULSE_AMP;
				remaining <= $bits(remaining)'(sonar_pkg::IMPULSE_LEN - 1);
			end else if (playing && step_in) begin
				if (remaining == '0) begin
					// impulse over, back to silence
					playing <= 1'b0;
					amp_out <= '0;
				end else begin
					remaining <= remaining - 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/window_energy.sv ====
`timescale 1ns/1ps
`default_nettype none

module window_energy (
	input logic clk_in,
	input logic rst_in,
	input logic step_in,
	input logic emit_start,
	input logic listen,
	input sonar_pkg::sample_t mic_in,
	output sonar_pkg::window_t window,
	output logic window_valid
);

	sonar_pkg::energy_t acc;	// running sum of the open window
	sonar_pkg::delay_t idx;		// index of the next sample
	sonar_pkg::energy_t sum;
	sonar_pkg::delay_t cur_idx;
	logic signed [31:0] square;
	logic take;
	logic closing;

	assign square = mic_in * mic_in;
	assign take = step_in && (listen || emit_start);

	// emit_start restarts the index and the sum at sample 0
	assign cur_idx = emit_start ? '0 : idx;
	assign sum = (emit_start ? '0 : acc) + sonar_pkg::energy_t'($unsigned(square));

	// last sample of an aligned window
	assign closing = (cur_idx % sonar_pkg::delay_t'(sonar_pkg::WINDOW_LEN))
		== sonar_pkg::delay_t'(sonar_pkg::WINDOW_LEN - 1);

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			window_valid <= 1'b0;
		end else begin
			window_valid <= take && closing;
		end
	end

	always_ff @(posedge clk_in) begin
		if (take) begin
			idx <= cur_idx + 1'b1;
			if (closing) begin
				window.energy <= sum;
				window.last_index <= cur_idx;
				acc <= '0;	// next window starts empty
			end else begin
				acc <= sum;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/onset_detector.sv ====
`timescale 1ns/1ps
`default_nettype none

module onset_detector (
	input logic clk_in,
	input logic rst_in,
	input logic emit_start,
	input sonar_pkg::window_t window,
	input logic window_valid,
	output sonar_pkg::verdict_t verdict,
	output logic verdict_valid
);

	// one extra bit so that 1.5 x max energy does not wrap
	typedef logic [$bits(sonar_pkg::energy_t):0] wide_energy_t;

	sonar_pkg::energy_t hist_1;	// previous window
	sonar_pkg::energy_t hist_2;	// the one before
	logic above_1;
	logic above_2;

	function automatic wide_energy_t one_and_half(input sonar_pkg::energy_t e);
		return {1'b0, e} + {2'b00, e[$bits(e)-1:1]};
	endfunction

	assign above_1 = {1'b0, window.energy} > one_and_half(hist_1);
	assign above_2 = {1'b0, window.energy} > one_and_half(hist_2);

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			verdict_valid <= 1'b0;
		end else begin
			verdict_valid <= window_valid && !emit_start;
		end
	end

	always_ff @(posedge clk_in) begin
		if (emit_start) begin
			// max energy history, first two windows of a ping never fire
			hist_1 <= '1;
			hist_2 <= '1;
		end else if (window_valid) begin
			hist_2 <= hist_1;
			hist_1 <= window.energy;
			verdict.onset <= above_1 && above_2;
			verdict.last_index <= window.last_index;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/range_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module range_controller (
	input logic clk_in,
	input logic rst_in,
	input logic step_in,
	input logic trigger,
	input logic emit_start,
	input sonar_pkg::verdict_t verdict,
	input logic verdict_valid,
	input logic result_ready,
	output logic ping_fire,
	output logic listen,
	output logic busy,
	output logic result_valid,
	output sonar_pkg::range_result_t result
);

	typedef enum logic [2:0] {
		idle,
		fire,
		await_impulse,
		analyse,
		pause,
		hold
	} state_t;

	state_t state;

	sonar_pkg::delay_t last_delay;	// delay of the latest onset ping
	sonar_pkg::delay_t prev_delay;	// delay of the one before
	logic [$clog2(sonar_pkg::MAX_PINGS + 1)-1:0] ping_count;
	logic [$clog2(sonar_pkg::PAUSE_STEPS)-1:0] pause_count;

	logic onset_seen;
	logic confirmed;
	logic ping_over;
	logic out_of_pings;

	assign ping_fire = (state == fire);
	assign listen = (state == analyse);
	assign busy = (state != idle);

	assign onset_seen = verdict_valid && verdict.onset;

	// third matching delay in a row
	assign confirmed = onset_seen
		&& verdict.last_index == last_delay
		&& verdict.last_index == prev_delay;

	// an onset or a window past the delay limit ends the ping
	assign ping_over = verdict_valid
		&& (verdict.onset || verdict.last_index >= sonar_pkg::MAX_DELAY);

	assign out_of_pings = (ping_count == sonar_pkg::MAX_PINGS);

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			state <= idle;
			result_valid <= 1'b0;
			ping_count <= '0;
			pause_count <= '0;
			last_delay <= sonar_pkg::NO_DELAY_NEW;
			prev_delay <= sonar_pkg::NO_DELAY_OLD;
		end else begin
			case (state)
				idle: begin
					if (trigger) begin
						last_delay <= sonar_pkg::NO_DELAY_NEW;
						prev_delay <= sonar_pkg::NO_DELAY_OLD;
						ping_count <= '0;
						state <= fire;
					end
				end

				fire: begin
					ping_count <= ping_count + 1'b1;
					state <= await_impulse;
				end

				await_impulse: begin
					if (emit_start) state <= analyse;	// listening starts at sample 0
				end

				analyse: begin
					if (onset_seen) begin
						prev_delay <= last_delay;
						last_delay <= verdict.last_index;
					end
					if (confirmed) begin
						result.status <= sonar_pkg::RANGE_OK;
						result.delay <= verdict.last_index;
						result_valid <= 1'b1;
						state <= hold;
					end else if (ping_over) begin
						if (out_of_pings) begin
							result.status <= sonar_pkg::RANGE_NO_ECHO;
							result.delay <= '0;
							result_valid <= 1'b1;
							state <= hold;
						end else begin
							pause_count <= '0;
							state <= pause;
						end
					end
				end

				pause: begin
					if (step_in) begin
						if (pause_count == $bits(pause_count)'(sonar_pkg::PAUSE_STEPS - 1)) begin
							state <= fire;
						end else begin
							pause_count <= pause_count + 1'b1;
						end
					end
				end

				hold: begin
					// result frozen until taken, triggers ignored
					if (result_ready) begin
						result_valid <= 1'b0;
						state <= idle;
					end
				end

				default: state <= idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/sonar_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sonar_top (
	input logic clk_in,
	input logic rst_in,
	input logic step_in,	// one cycle per audio sample
	input logic trigger,
	input sonar_pkg::sample_t mic_in,
	output sonar_pkg::sample_t amp_out,
	output logic busy,
	output sonar_pkg::range_result_t result,
	output logic result_valid,
	input logic result_ready
);

	logic ping_fire;
	logic emit_start;
	logic listen;
	sonar_pkg::window_t window;
	logic window_valid;
	sonar_pkg::verdict_t verdict;
	logic verdict_valid;

	impulse_generator impulse_generator_inst (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.step_in(step_in),
		.ping_fire(ping_fire),
		.emit_start(emit_start),
		.amp_out(amp_out)
	);

	window_energy window_energy_inst (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.step_in(step_in),
		.emit_start(emit_start),
		.listen(listen),
		.mic_in(mic_in),
		.window(window),
		.window_valid(window_valid)
	);

	onset_detector onset_detector_inst (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.emit_start(emit_start),
		.window(window),
		.window_valid(window_valid),
		.verdict(verdict),
		.verdict_valid(verdict_valid)
	);

	range_controller range_controller_inst (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.step_in(step_in),
		.trigger(trigger),
		.emit_start(emit_start),
		.verdict(verdict),
		.verdict_valid(verdict_valid),
		.result_ready(result_ready),
		.ping_fire(ping_fire),
		.listen(listen),
		.busy(busy),
		.result_valid(result_valid),
		.result(result)
	);

endmodule

`default_nettype wire

// ==== verification/sonar_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sonar_tb;

	localparam int NUM_ROWS = 5;
	// worst case every row runs out of pings, plus room for stalls and gaps
	localparam int TIMEOUT_CYCLES = NUM_ROWS * sonar_pkg::MAX_PINGS
		* (int'(sonar_pkg::MAX_DELAY) + sonar_pkg::PAUSE_STEPS + 20) * 4 + 4000;

	typedef struct packed {
		sonar_pkg::delay_t echo_delay;	// first echo sample index
		sonar_pkg::sample_t echo_amp;
		logic silent;			// no echo at all
		logic stalled;			// ready held low for a random time
		sonar_pkg::range_result_t expected;
	} row_t;

	logic clk_in;
	logic rst_in;
	logic step_in;
	logic trigger;
	sonar_pkg::sample_t mic_in;
	sonar_pkg::sample_t amp_out;
	logic busy;
	sonar_pkg::range_result_t result;
	logic result_valid;
	logic result_ready;

	row_t rows [NUM_ROWS];
	int error_count;
	int check_total;
	int impulse_count;	// impulses seen on amp_out
	int run_len;		// strobes of the current impulse
	int next_idx;		// echo model index of the next strobe
	int phase;
	int cycles;

	// echo model settings of the current row
	sonar_pkg::delay_t echo_delay;
	sonar_pkg::sample_t echo_amp;
	logic echo_on;

	sonar_top sonar_top_inst (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.step_in(step_in),
		.trigger(trigger),
		.mic_in(mic_in),
		.amp_out(amp_out),
		.busy(busy),
		.result(result),
		.result_valid(result_valid),
		.result_ready(result_ready)
	);

	always #20 clk_in = ~clk_in;

	task automatic check_result(input sonar_pkg::range_result_t got,
		input sonar_pkg::range_result_t exp);
		check_total++;
		if (got !== exp) begin
			error_count++;
			$display("error result got %h expected %h", got, exp);
		end
	endtask

	task automatic check_amp(input string name, input sonar_pkg::sample_t got,
		input sonar_pkg::sample_t exp);
		check_total++;
		if (got !== exp) begin
			error_count++;
			$display("error %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		check_total++;
		if (got !== exp) begin
			error_count++;
			$display("error %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		check_total++;
		if (got != exp) begin
			error_count++;
			$display("error %s got %h expected %h", name, got, exp);
		end
	endtask

	function automatic row_t make_row(input sonar_pkg::delay_t d, input sonar_pkg::sample_t a,
		input logic silent, input logic stalled, input sonar_pkg::range_status_t st,
		input sonar_pkg::delay_t exp_delay);
		row_t r;
		r.echo_delay = d;
		r.echo_amp = a;
		r.silent = silent;
		r.stalled = stalled;
		r.expected.status = st;
		r.expected.delay = exp_delay;
		return r;
	endfunction

	// echo lasts two windows from echo_delay on
	function automatic sonar_pkg::sample_t echo_sample(input int idx);
		if (echo_on && idx >= int'(echo_delay)
			&& idx < int'(echo_delay) + 2 * sonar_pkg::WINDOW_LEN) begin
			return echo_amp;
		end
		return '0;
	endfunction

	// strobe generator, echo model and impulse monitor
	always @(negedge clk_in) begin
		if (step_in) begin	// a strobe was taken at the last rising edge
			if (amp_out != '0) begin
				if (run_len == 0) begin
					impulse_count++;
					next_idx = 1;	// that strobe was index 0
				end
				run_len++;
				check_amp("amp_out", amp_out, sonar_pkg::IMPULSE_AMP);
			end else if (run_len != 0) begin
				check_count("impulse length", run_len, sonar_pkg::IMPULSE_LEN);
				run_len = 0;
			end
		end
		phase = (phase + 1) % 4;
		step_in = (phase == 0);
		if (step_in) begin
			mic_in = echo_sample(next_idx);
			next_idx++;
		end else begin
			mic_in = '0;
		end
	end

	initial begin
		int base;
		int stall;
		int exp_pings;
		sonar_pkg::range_result_t held;

		void'($urandom(32'h9279c9db));
		clk_in = 1'b0;
		rst_in = 1'b1;
		step_in = 1'b0;
		trigger = 1'b0;
		mic_in = '0;
		result_ready = 1'b0;
		error_count = 0;
		check_total = 0;
		impulse_count = 0;
		run_len = 0;
		next_idx = 100000;	// far from any echo until the first impulse
		phase = 0;
		echo_delay = '0;
		echo_amp = '0;
		echo_on = 1'b0;

		// expected delay closes the window holding the echo start
		rows[0] = make_row(12'd40, 16'sd3000, 1'b0, 1'b0, sonar_pkg::RANGE_OK, 12'd47);
		rows[1] = make_row(12'd101, -16'sd1200, 1'b0, 1'b1, sonar_pkg::RANGE_OK, 12'd103);
		rows[2] = make_row(12'd0, 16'sd0, 1'b1, 1'b1, sonar_pkg::RANGE_NO_ECHO, 12'd0);
		rows[3] = make_row(12'd16, 16'sd500, 1'b0, 1'b0, sonar_pkg::RANGE_OK, 12'd23);
		rows[4] = make_row(12'd230, 16'sd20000, 1'b0, 1'b1, sonar_pkg::RANGE_OK, 12'd231);

		repeat (8) @(negedge clk_in);
		rst_in = 1'b0;
		@(negedge clk_in);
		check_amp("amp_out", amp_out, 16'sd0);
		check_flag("result_valid", result_valid, 1'b0);
		check_flag("busy", busy, 1'b0);

		for (int r = 0; r < NUM_ROWS; r++) begin
			echo_delay = rows[r].echo_delay;
			echo_amp = rows[r].echo_amp;
			echo_on = !rows[r].silent;
			exp_pings = rows[r].silent ? sonar_pkg::MAX_PINGS : 3;
			base = impulse_count;

			@(negedge clk_in);
			trigger = 1'b1;
			@(negedge clk_in);
			trigger = 1'b0;
			while (result_valid !== 1'b1) @(negedge clk_in);

			held = result;
			check_result(result, rows[r].expected);
			check_count("pings", impulse_count - base, exp_pings);
			base = impulse_count;

			if (rows[r].stalled) begin
				stall = 4 + int'($urandom % 16);
				trigger = 1'b1;	// must not start a new ping while held
				repeat (stall) begin
					@(negedge clk_in);
					trigger = 1'b0;
					check_result(result, held);
					check_flag("result_valid", result_valid, 1'b1);
					check_flag("busy", busy, 1'b1);
				end
			end

			result_ready = 1'b1;
			@(negedge clk_in);
			result_ready = 1'b0;
			check_flag("result_valid", result_valid, 1'b0);	// taken on first ready

			repeat (12) @(negedge clk_in);
			check_flag("busy", busy, 1'b0);
			@(posedge clk_in);
			check_count("impulses after result", impulse_count - base, 0);
		end

		$display("checks %0d errors %0d", check_total, error_count);
		if (error_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk_in);
			cycles++;
		end
		$display("the run timed out after %0d cycles before all rows were done", cycles);
		$display("checks %0d errors %0d", check_total, error_count);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
hdl/sonar_pkg.sv
hdl/impulse_generator.sv
hdl/window_energy.sv
hdl/onset_detector.sv
hdl/range_controller.sv
hdl/sonar_top.sv
verification/sonar_tb.sv

// ==== Bender.yml ====
package:
  name: sonar

sources:
  - hdl/sonar_pkg.sv
  - hdl/impulse_generator.sv
  - hdl/window_energy.sv
  - hdl/onset_detector.sv
  - hdl/range_controller.sv
  - hdl/sonar_top.sv
  - target: test
    files:
      - verification/sonar_tb.sv
